//--- project.f
iotdf_pkg.sv
iotdf_ctrl.sv
byte_loader.sv
crc3_engine.sv
minmax_tracker.sv
iotdf_top.sv
tb_iotdf.sv

//--- run.sh
#!/bin/sh
# build and run the IoT data filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_iotdf -f project.f -o sim_tb_iotdf; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_iotdf)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Test passed'; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tb_iotdf.sv
`timescale 1ns/1ps

module tb_iotdf;
  import iotdf_pkg::*;

  // data kinds for the stimulus table
  localparam logic [2:0] K_RANDOM = 3'd0;
  localparam logic [2:0] K_ZEROS  = 3'd1;
  localparam logic [2:0] K_ONES   = 3'd2;
  localparam logic [2:0] K_DESC   = 3'd3;
  localparam logic [2:0] K_DUPS   = 3'd4;

  typedef struct packed {
    fn_sel_t    fn;
    logic [7:0] blocks;
    logic [2:0] kind;
  } row_t;

  localparam int   NUM_ROWS = 6;
  localparam row_t ROWS [NUM_ROWS] = '{
    '{FN_CRC_GEN,  8'd4,  K_RANDOM},
    '{FN_CRC_GEN,  8'd1,  K_ZEROS},
    '{FN_CRC_GEN,  8'd1,  K_ONES},
    '{FN_TOP2MAX,  8'd16, K_DUPS},
    '{FN_LAST2MIN, 8'd16, K_DESC},
    '{3'b111,      8'd16, K_RANDOM}
  };

  logic      i_clk;
  logic      i_rst;
  logic      i_in_en;
  iot_byte_t i_iot_in;
  fn_sel_t   i_fn_sel;
  logic      o_busy;
  logic      o_valid;
  block_t    o_iot_out;

  int     seed        = 32'h1c3c;
  int     cycle_count = 0;
  int     busy_rises  = 0;
  logic   busy_seen   = 1'b0;
  block_t blk_q[$];
  block_t exp_q[$];
  block_t got_q[$];

  iotdf_top iotdf_top_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in_en   (i_in_en),
    .i_iot_in  (i_iot_in),
    .i_fn_sel  (i_fn_sel),
    .o_busy    (o_busy),
    .o_valid   (o_valid),
    .o_iot_out (o_iot_out)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // 20 cycles per block plus slack
  function automatic int cycle_limit();
    int total;
    total = 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += 20 * int'(ROWS[r].blocks);
    end
    return total;
  endfunction

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit()) begin
      $display("timeout: run did not complete within %0d cycles", cycle_limit());
      $display("Test failed");
      $fatal(1, "simulation timed out");
    end
  end

  // outputs are stable mid-cycle
  always @(negedge i_clk) begin
    if (o_valid) begin
      got_q.push_back(o_iot_out);
    end
    if (o_busy && !busy_seen) begin
      busy_rises++;
    end
    busy_seen = o_busy;
  end

  task automatic check_value(input string what, input block_t got, input block_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // long division of blk * x^3 by the generator
  function automatic block_t crc_model(block_t blk);
    logic [BLOCK_W+CRC_W-1:0] dvd;
    dvd = {blk, {CRC_W{1'b0}}};
    for (int i = BLOCK_W + CRC_W - 1; i >= CRC_W; i--) begin
      if (dvd[i]) begin
        dvd[i -: CRC_W+1] = dvd[i -: CRC_W+1] ^ CRC_POLY;
      end
    end
    return block_t'(dvd[CRC_W-1:0]);
  endfunction

  function automatic logic ranks_ahead(block_t a, block_t b, logic find_max);
    return find_max ? (a > b) : (a < b);
  endfunction

  // stable insertion sort of one set, keep the first two
  task automatic expect_top_two(input int first, input logic find_max);
    block_t srt[BLOCKS_PER_SET];
    block_t tmp;
    for (int k = 0; k < BLOCKS_PER_SET; k++) begin
      srt[k] = blk_q[first + k];
    end
    for (int i = 1; i < BLOCKS_PER_SET; i++) begin
      for (int j = i; j > 0; j--) begin
        if (ranks_ahead(srt[j], srt[j-1], find_max)) begin
          tmp      = srt[j];
          srt[j]   = srt[j-1];
          srt[j-1] = tmp;
        end
      end
    end
    exp_q.push_back(srt[0]);
    exp_q.push_back(srt[1]);
  endtask

  task automatic make_blocks(input logic [2:0] kind, input int count);
    block_t      blk;
    logic [31:0] rnd;
    iot_byte_t   d;
    blk_q.delete();
    for (int k = 0; k < count; k++) begin
      for (int b = 0; b < BYTES_PER_BLOCK; b++) begin
        rnd = $random(seed);
        blk = {blk[BLOCK_W-IOT_BYTE_W-1:0], rnd[7:0]};
      end
      d = 8'd240 - 8'(k * 16);
      case (kind)
        K_ZEROS: blk = '0;
        K_ONES:  blk = '1;
        // first set descends, second set stays random
        K_DESC: begin
          if (k < BLOCKS_PER_SET) begin
            blk = {BYTES_PER_BLOCK{d}};
          end
        end
        // second set holds its maximum twice
        K_DUPS: begin
          if (k == 10 || k == 13) begin
            blk = '1;
          end
        end
        default: ;
      endcase
      blk_q.push_back(blk);
    end
  endtask

  task automatic apply_reset(input fn_sel_t fn);
    @(posedge i_clk);
    #1;
    i_rst    = 1'b1;
    i_in_en  = 1'b0;
    i_iot_in = '0;
    i_fn_sel = fn;
    repeat (10) begin
      @(negedge i_clk);
      check_value("o_valid in reset", block_t'(o_valid), '0);
      check_value("o_busy in reset", block_t'(o_busy), '0);
    end
    @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    check_value("o_valid after reset", block_t'(o_valid), '0);
    check_value("o_busy after reset", block_t'(o_busy), '0);
    check_value("o_iot_out after reset", o_iot_out, '0);
  endtask

  // enable stays high, junk goes in while busy
  task automatic stream_blocks();
    int          idx;
    block_t      cur;
    logic [31:0] rnd;
    idx = 0;
    while (idx < blk_q.size() * BYTES_PER_BLOCK) begin
      @(posedge i_clk);
      #1;
      i_in_en = 1'b1;
      if (o_busy) begin
        rnd      = $random(seed);
        i_iot_in = rnd[7:0];
      end else begin
        cur      = blk_q[idx / BYTES_PER_BLOCK];
        i_iot_in = cur[BLOCK_W - 1 - IOT_BYTE_W * (idx % BYTES_PER_BLOCK) -: IOT_BYTE_W];
        idx++;
      end
    end
    @(posedge i_clk);
    #1;
    i_in_en = 1'b0;
  endtask

  task automatic run_row(input row_t row);
    int base_res;
    int base_busy;
    int exp_busy;
    apply_reset(row.fn);
    base_res  = got_q.size();
    base_busy = busy_rises;
    make_blocks(row.kind, int'(row.blocks));
    exp_q.delete();
    exp_busy = 0;
    if (row.fn == FN_CRC_GEN) begin
      exp_busy = int'(row.blocks);
      foreach (blk_q[k]) begin
        exp_q.push_back(crc_model(blk_q[k]));
      end
    end else if (row.fn == FN_TOP2MAX || row.fn == FN_LAST2MIN) begin
      for (int s = 0; s < int'(row.blocks); s += BLOCKS_PER_SET) begin
        expect_top_two(s, row.fn == FN_TOP2MAX);
      end
    end
    stream_blocks();
    while (got_q.size() < base_res + exp_q.size()) begin
      @(posedge i_clk);
    end
    // room for any stray pulse
    repeat (16) @(posedge i_clk);
    check_value("result count", block_t'(got_q.size() - base_res), block_t'(exp_q.size()));
    check_value("busy rises", block_t'(busy_rises - base_busy), block_t'(exp_busy));
    for (int n = 0; n < exp_q.size(); n++) begin
      check_value($sformatf("result %0d", n), got_q[base_res + n], exp_q[n]);
    end
  endtask

  initial begin
    i_rst    = 1'b1;
    i_in_en  = 1'b0;
    i_iot_in = '0;
    i_fn_sel = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(ROWS[r]);
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- iotdf_top.sv
`timescale 1ns/1ps

module iotdf_top (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_in_en,
  input  iotdf_pkg::iot_byte_t i_iot_in,
  input  iotdf_pkg::fn_sel_t   i_fn_sel,
  output logic                 o_busy,
  output logic                 o_valid,
  output iotdf_pkg::block_t    o_iot_out
);
  import iotdf_pkg::*;

  logic       byte_accept;
  logic       block_strobe;
  block_t     block_data;
  block_idx_t block_idx;
  logic       crc_start;
  logic       crc_valid;
  logic       crc_busy;
  crc_t       crc_result;
  logic       mm_update;
  logic       find_max;
  logic       mm_valid;
  block_t     mm_result;

  iotdf_ctrl ctrl_i (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_in_en        (i_in_en),
    .i_fn_sel       (i_fn_sel),
    .i_block_strobe (block_strobe),
    .i_crc_valid    (crc_valid),
    .i_crc_result   (crc_result),
    .i_crc_busy     (crc_busy),
    .i_mm_valid     (mm_valid),
    .i_mm_result    (mm_result),
    .o_byte_accept  (byte_accept),
    .o_crc_start    (crc_start),
    .o_mm_update    (mm_update),
    .o_find_max     (find_max),
    .o_busy         (o_busy),
    .o_valid        (o_valid),
    .o_iot_out      (o_iot_out)
  );

  byte_loader loader_i (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_byte_accept  (byte_accept),
    .i_iot_in       (i_iot_in),
    .o_block_strobe (block_strobe),
    .o_block_data   (block_data),
    .o_block_idx    (block_idx)
  );

  crc3_engine crc_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (crc_start),
    .i_block (block_data),
    .o_busy  (crc_busy),
    .o_valid (crc_valid),
    .o_crc   (crc_result)
  );

  minmax_tracker minmax_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_update    (mm_update),
    .i_block     (block_data),
    .i_block_idx (block_idx),
    .i_find_max  (find_max),
    .o_valid     (mm_valid),
    .o_result    (mm_result)
  );

endmodule

//--- minmax_tracker.sv
`timescale 1ns/1ps

module minmax_tracker (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_update,
  input  iotdf_pkg::block_t     i_block,
  input  iotdf_pkg::block_idx_t i_block_idx,
  input  logic                  i_find_max,
  output logic                  o_valid,
  output iotdf_pkg::block_t     o_result
);
  import iotdf_pkg::*;

  block_t best_q;
  block_t second_q;
  block_t best_nxt;
  block_t second_nxt;
  block_t fin_best_q;
  block_t fin_second_q;
  logic   beats_best;
  logic   beats_second;
  logic   set_done;
  logic   emit_best_q;
  logic   emit_second_q;

  // strict compare so ties never displace
  function automatic logic better(block_t a, block_t b, logic find_max);
    return find_max ? (a > b) : (a < b);
  endfunction

  assign beats_best   = better(i_block, best_q, i_find_max);
  assign beats_second = better(i_block, second_q, i_find_max);
  assign set_done     = i_update && (i_block_idx == block_idx_t'(BLOCKS_PER_SET - 1));

  always_comb begin
    best_nxt   = best_q;
    second_nxt = second_q;
    if (i_block_idx == '0) begin
      // new set starts runner-up at the weakest value
      best_nxt   = i_block;
      second_nxt = i_find_max ? '0 : '1;
    end else if (beats_best) begin
      second_nxt = best_q;
      best_nxt   = i_block;
    end else if (beats_second) begin
      second_nxt = i_block;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_update) begin
      best_q   <= best_nxt;
      second_q <= second_nxt;
    end
    if (set_done) begin
      fin_best_q   <= best_nxt;
      fin_second_q <= second_nxt;
    end
  end

  // best goes out first and runner-up on the next cycle
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      emit_best_q   <= 1'b0;
      emit_second_q <= 1'b0;
    end else begin
      emit_best_q   <= set_done;
      emit_second_q <= emit_best_q;
    end
  end

  assign o_valid  = emit_best_q || emit_second_q;
  assign o_result = emit_second_q ? fin_second_q : fin_best_q;

  // a set may not finish while the previous pair is still going out
  a_pulse_pair: assert property (
    @(posedge i_clk) disable iff (i_rst) set_done |-> !o_valid
  );

endmodule

//--- crc3_engine.sv
`timescale 1ns/1ps

module crc3_engine (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start,
  input  iotdf_pkg::block_t i_block,
  output logic              o_busy,
  output logic              o_valid,
  output iotdf_pkg::crc_t   o_crc
);
  import iotdf_pkg::*;

  block_t    blk_q;
  crc_t      rem_q;
  byte_idx_t step_q;
  logic      busy_q;
  logic      valid_q;
  logic      working;
  logic      last_step;

  // shift one dividend bit into the remainder
  function automatic crc_t div_bit(crc_t rem, logic b);
    logic [CRC_W:0] t;
    t = {rem, b};
    if (t[CRC_W]) begin
      t = t ^ CRC_POLY;
    end
    return t[CRC_W-1:0];
  endfunction

  function automatic crc_t div_byte(crc_t rem, iot_byte_t data);
    crc_t r;
    r = rem;
    for (int i = IOT_BYTE_W - 1; i >= 0; i--) begin
      r = div_bit(r, data[i]);
    end
    return r;
  endfunction

  // the x^3 factor appends three zero bits
  function automatic crc_t flush_zeros(crc_t rem);
    crc_t r;
    r = rem;
    for (int i = 0; i < CRC_W; i++) begin
      r = div_bit(r, 1'b0);
    end
    return r;
  endfunction

  assign working   = busy_q && !valid_q;
  assign last_step = working && (step_q == byte_idx_t'(BYTES_PER_BLOCK - 1));

  // byte 0 is divided on the capture edge itself
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      blk_q <= i_block << IOT_BYTE_W;
      rem_q <= div_byte('0, i_block[BLOCK_W-1 -: IOT_BYTE_W]);
    end else if (working) begin
      blk_q <= blk_q << IOT_BYTE_W;
      if (last_step) begin
        rem_q <= flush_zeros(div_byte(rem_q, blk_q[BLOCK_W-1 -: IOT_BYTE_W]));
      end else begin
        rem_q <= div_byte(rem_q, blk_q[BLOCK_W-1 -: IOT_BYTE_W]);
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      step_q  <= '0;
    end else begin
      valid_q <= last_step;
      if (i_start) begin
        busy_q <= 1'b1;
        step_q <= byte_idx_t'(1);
      end else if (valid_q) begin
        busy_q <= 1'b0;
      end else if (working && !last_step) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  assign o_busy  = busy_q;
  assign o_valid = valid_q;
  assign o_crc   = rem_q;

  // loader and controller must hold off the next block
  a_no_start_while_busy: assert property (
    @(posedge i_clk) disable iff (i_rst) i_start |-> !o_busy
  );

endmodule

//--- byte_loader.sv
`timescale 1ns/1ps

module byte_loader (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_byte_accept,
  input  iotdf_pkg::iot_byte_t  i_iot_in,
  output logic                  o_block_strobe,
  output iotdf_pkg::block_t     o_block_data,
  output iotdf_pkg::block_idx_t o_block_idx
);
  import iotdf_pkg::*;

  block_t     shift_q;
  byte_idx_t  byte_cnt_q;
  block_idx_t block_cnt_q;
  logic       strobe_q;
  logic       last_byte;

  assign last_byte = i_byte_accept && (byte_cnt_q == byte_idx_t'(BYTES_PER_BLOCK - 1));

  // first byte ends up in the top byte lane
  always_ff @(posedge i_clk) begin
    if (i_byte_accept) begin
      shift_q <= {shift_q[BLOCK_W-IOT_BYTE_W-1:0], i_iot_in};
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      strobe_q    <= 1'b0;
      byte_cnt_q  <= '0;
      block_cnt_q <= '0;
    end else begin
      strobe_q <= last_byte;
      if (i_byte_accept) begin
        byte_cnt_q <= last_byte ? '0 : byte_cnt_q + 1'b1;
      end
      // set position advances once the block has been handed off
      if (strobe_q) begin
        if (block_cnt_q == block_idx_t'(BLOCKS_PER_SET - 1)) begin
          block_cnt_q <= '0;
        end else begin
          block_cnt_q <= block_cnt_q + 1'b1;
        end
      end
    end
  end

  assign o_block_strobe = strobe_q;
  assign o_block_data   = shift_q;
  assign o_block_idx    = block_cnt_q;

endmodule

//--- iotdf_ctrl.sv
`timescale 1ns/1ps

module iotdf_ctrl (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_in_en,
  input  iotdf_pkg::fn_sel_t i_fn_sel,
  input  logic               i_block_strobe,
  input  logic               i_crc_valid,
  input  iotdf_pkg::crc_t    i_crc_result,
  input  logic               i_crc_busy,
  input  logic               i_mm_valid,
  input  iotdf_pkg::block_t  i_mm_result,
  output logic               o_byte_accept,
  output logic               o_crc_start,
  output logic               o_mm_update,
  output logic               o_find_max,
  output logic               o_busy,
  output logic               o_valid,
  output iotdf_pkg::block_t  o_iot_out
);
  import iotdf_pkg::*;

  logic   crc_mode;
  logic   max_mode;
  logic   mm_mode;
  logic   fn_active;
  logic   valid_nxt;
  logic   valid_q;
  block_t out_nxt;
  block_t out_q;

  // function decode
  assign crc_mode  = (i_fn_sel == FN_CRC_GEN);
  assign max_mode  = (i_fn_sel == FN_TOP2MAX);
  assign mm_mode   = max_mode || (i_fn_sel == FN_LAST2MIN);
  assign fn_active = crc_mode || mm_mode;

  // back-pressure only comes from the crc engine
  assign o_busy        = crc_mode && i_crc_busy;
  assign o_byte_accept = fn_active && i_in_en && !o_busy;

  // steer finished blocks to the active engine
  assign o_crc_start = crc_mode && i_block_strobe;
  assign o_mm_update = mm_mode && i_block_strobe;
  assign o_find_max  = max_mode;

  always_comb begin
    valid_nxt = 1'b0;
    out_nxt   = '0;
    if (crc_mode && i_crc_valid) begin
      valid_nxt = 1'b1;
      out_nxt   = block_t'(i_crc_result);
    end else if (mm_mode && i_mm_valid) begin
      valid_nxt = 1'b1;
      out_nxt   = i_mm_result;
    end
  end

  // output stage, zero between results
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      valid_q <= 1'b0;
      out_q   <= '0;
    end else begin
      valid_q <= valid_nxt;
      out_q   <= out_nxt;
    end
  end

  assign o_valid   = valid_q;
  assign o_iot_out = out_q;

  a_crc_only_in_crc_mode: assert property (
    @(posedge i_clk) disable iff (i_rst) i_crc_valid |-> crc_mode
  );

endmodule

//--- iotdf_pkg.sv
package iotdf_pkg;

  // stream and block geometry
  localparam int IOT_BYTE_W      = 8;
  localparam int BLOCK_W         = 128;
  localparam int BYTES_PER_BLOCK = 16;
  localparam int BLOCKS_PER_SET  = 8;

  // crc remainder and generator x^3 + x^2 + x
  localparam int             CRC_W    = 3;
  localparam logic [CRC_W:0] CRC_POLY = 4'b1110;

  typedef logic [IOT_BYTE_W-1:0]                iot_byte_t;
  typedef logic [BLOCK_W-1:0]                   block_t;
  typedef logic [2:0]                           fn_sel_t;
  typedef logic [$clog2(BYTES_PER_BLOCK)-1:0]   byte_idx_t;
  typedef logic [$clog2(BLOCKS_PER_SET)-1:0]    block_idx_t;
  typedef logic [CRC_W-1:0]                     crc_t;

  // function codes, other values are idle
  localparam fn_sel_t FN_CRC_GEN  = 3'b011;
  localparam fn_sel_t FN_TOP2MAX  = 3'b100;
  localparam fn_sel_t FN_LAST2MIN = 3'b101;

endpackage
